/* filelist.f */
source/ex_types_pkg.sv
source/ex_packets_pkg.sv
source/alu_fu.sv
source/load_fu.sv
source/store_fu.sv
source/cdb_arbiter.sv
source/ex_stage.sv
source/ex_top.sv
tb/ex_properties.sv
tb/ex_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --assert --top-module ex_tb -f filelist.f -o ex_sim > build.log 2>&1 \
    && ./obj_dir/ex_sim +verilator+error+limit+100 > sim.log 2>&1 \
    && ! grep -q "TESTS FAILED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb/ex_tb.sv */
// memory model holds 256 words below address 0x400; unit order is ALU, ALU, load, store
`timescale 1ns/1ps

module ex_tb
    import ex_types_pkg::*;
    import ex_packets_pkg::*;
();

    localparam int WAIT_LIMIT = 20;
    localparam int MEM_WORDS  = 256;

    logic                 clock = 1'b0;
    logic                 rst_n;
    fu_in_t  [NUM_FU-1:0] issue;
    rob_tag_t             rob_head;
    data_t                mem_rdata;
    logic    [NUM_FU-1:0] fu_ready;
    mem_req_t             mem_req;
    cdb_t                 cdb;
    branch_t              branch;

    data_t mem [MEM_WORDS];
    int    value_errors = 0;
    int    timeouts = 0;

    ex_top #(
        .NUM_FU (NUM_FU)
    ) DUT (
        .clock     (clock),
        .rst_n     (rst_n),
        .issue     (issue),
        .rob_head  (rob_head),
        .mem_rdata (mem_rdata),
        .fu_ready  (fu_ready),
        .mem_req   (mem_req),
        .cdb       (cdb),
        .branch    (branch)
    );

    bind ex_top ex_properties u_props (
        .clock    (clock),
        .rst_n    (rst_n),
        .issue    (issue),
        .fu_ready (fu_ready),
        .ack      (ack),
        .fu_outs  (fu_outs),
        .mem_req  (mem_req),
        .cdb      (cdb),
        .branch   (branch)
    );

    always #4 clock = ~clock;

    // every address bit mixes into the word
    function automatic data_t fill_word(input addr_t a);
        return (a * 32'h9e3779b1) ^ 32'h5a3c96e1;
    endfunction

    // word-addressed memory, read in the same cycle as the request
    assign mem_rdata = mem[mem_req.addr[9:2]];

    always @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= fill_word(addr_t'(i * 4));
            end
        end else if (mem_req.valid && mem_req.write) begin
            mem[mem_req.addr[9:2]] <= mem_req.wdata;
        end
    end

    function automatic fu_in_t make_issue(input alu_op_t op, input rob_tag_t tag,
                                          input data_t a, input data_t b, input data_t imm,
                                          input addr_t pc, input reg_idx_t dest);
        return '{issue_valid: 1'b1, rob_tag: tag, alu_op: op, opa: a, opb: b,
                 imm: imm, pc: pc, dest_reg: dest};
    endfunction

    // second operand is opb for SUB and SLT, imm for the rest
    function automatic data_t alu_model(input alu_op_t op, input data_t a, input data_t b,
                                        input data_t imm);
        data_t src;
        src = (op == SUB || op == SLT) ? b : imm;
        case (op)
            ADD:     return a + src;
            SUB:     return a - src;
            AND:     return a & src;
            OR:      return a | src;
            XOR:     return a ^ src;
            SLT:     return ($signed(a) < $signed(src)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_eq(input data_t got, input data_t exp, input string what);
        assert (got === exp) else begin
            value_errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        assert (got === exp) else begin
            value_errors++;
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_for_tag(input rob_tag_t tag, input string what);
        int n;
        n = 0;
        while (!(cdb.valid && cdb.rob_tag == tag) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!(cdb.valid && cdb.rob_tag == tag)) begin
            timeouts++;
            $display("timeout: %s never appeared on the CDB", what);
        end
    endtask

    initial begin
        alu_op_t ops [6];
        alu_op_t op;
        data_t   a;
        data_t   b;
        data_t   imm;
        data_t   ld_addr;
        data_t   st_addr;
        data_t   st_data;
        int      unit;
        int      total;
        bit      seen;

        ops = '{ADD, SUB, AND, OR, XOR, SLT};
        void'($urandom(32'hfbc35538));
        rst_n    = 1'b0;
        issue    = '0;
        rob_head = 5'd1;
        repeat (2) @(posedge clock);
        #1;
        check_flag(cdb.valid, 1'b0, "cdb.valid after reset");
        check_flag(branch.valid, 1'b0, "branch.valid after reset");
        check_flag(mem_req.valid, 1'b0, "mem_req.valid after reset");
        check_eq(data_t'(fu_ready), 32'hf, "fu_ready after reset");
        rst_n = 1'b1;

        // random ops, alternating between the two ALUs
        for (int k = 0; k < 8; k++) begin
            op   = ops[$urandom % 6];
            a    = $urandom;
            b    = $urandom;
            imm  = $urandom;
            unit = k % 2;
            issue[unit] = make_issue(op, rob_tag_t'(k + 1), a, b, imm, '0, reg_idx_t'(k + 3));
            next_cycle();
            issue = '0;
            check_flag(cdb.valid, 1'b1, "ALU result valid");
            check_eq(data_t'(cdb.rob_tag), data_t'(k + 1), "ALU result tag");
            check_eq(data_t'(cdb.dest_reg), data_t'(k + 3), "ALU result destination");
            check_eq(cdb.value, alu_model(op, a, b, imm), "ALU result value");
            next_cycle();
        end

        // both ALUs finish together
        a = $urandom;
        b = $urandom;
        issue[0] = make_issue(ADD, 5'd10, a, b, 32'h11, '0, 5'd1);
        issue[1] = make_issue(XOR, 5'd11, b, a, 32'h22, '0, 5'd2);
        next_cycle();
        issue = '0;
        check_eq(data_t'(cdb.rob_tag), 32'd10, "first of two ALU results");
        check_flag(fu_ready[1], 1'b0, "ALU 1 ready while its result waits");
        next_cycle();
        check_eq(data_t'(cdb.rob_tag), 32'd11, "second of two ALU results");
        check_eq(cdb.value, alu_model(XOR, b, a, 32'h22), "second ALU value");
        check_flag(fu_ready[1], 1'b1, "ALU 1 ready when acked");
        next_cycle();
        check_flag(cdb.valid, 1'b0, "CDB idle after both results");

        // load and store issued together, load takes the port first
        rob_head = 5'd20;
        ld_addr  = ($urandom % 128) * 4;
        st_addr  = 32'h200 + ($urandom % 128) * 4;
        st_data  = $urandom;
        issue[2] = make_issue(ADD, 5'd20, ld_addr - 32'h10, '0, 32'h10, '0, 5'd7);
        // a store reports destination 0 whatever it was issued with
        issue[3] = make_issue(ADD, 5'd21, st_addr - 32'h4, st_data, 32'h4, '0, 5'd8);
        next_cycle();
        issue = '0;
        check_flag(mem_req.valid, 1'b1, "load request valid");
        check_flag(mem_req.write, 1'b0, "load request write");
        check_eq(mem_req.addr, ld_addr, "load address");
        wait_for_tag(5'd20, "the load result");
        check_eq(cdb.value, fill_word(ld_addr), "load value");
        check_eq(data_t'(cdb.dest_reg), 32'd7, "load destination");
        check_flag(mem_req.write, 1'b1, "store request after the load");
        check_eq(mem_req.addr, st_addr, "store address");
        wait_for_tag(5'd21, "the store completion");
        check_eq(data_t'(cdb.dest_reg), 32'd0, "store destination");
        check_eq(mem[st_addr[9:2]], st_data, "stored word");
        next_cycle();

        // taken branch with tags wrapping past 31
        rob_head = 5'd30;
        ld_addr  = ($urandom % 128) * 4;
        st_addr  = 32'h200 + ($urandom % 128) * 4;
        st_data  = $urandom;
        issue[2] = make_issue(ADD, 5'd1, ld_addr, '0, '0, '0, 5'd9);
        issue[3] = make_issue(ADD, 5'd30, st_addr, st_data, '0, '0, 5'd0);
        next_cycle();
        issue = '0;
        a = $urandom;
        issue[0] = make_issue(BEQ, 5'd31, a, a, 32'h40, 32'h1000, 5'd0);
        issue[1] = make_issue(ADD, 5'd2, a, a, 32'h5, '0, 5'd4);
        next_cycle();
        issue = '0;
        check_flag(branch.valid, 1'b1, "taken BEQ branch valid");
        check_eq(data_t'(branch.rob_tag), 32'd31, "branch tag");
        check_eq(branch.target, 32'h1040, "branch target");
        check_eq(data_t'(cdb.rob_tag), 32'd31, "CDB tag with the branch");
        // younger issue offered in the squash cycle
        issue[0] = make_issue(ADD, 5'd3, a, a, 32'h1, '0, 5'd5);
        next_cycle();
        issue = '0;
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            check_flag(cdb.valid && cdb.rob_tag inside {5'd1, 5'd2, 5'd3}, 1'b0,
                       "squashed result on the CDB");
            if (cdb.valid && cdb.rob_tag == 5'd30) begin
                seen = 1'b1;
            end else begin
                next_cycle();
            end
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: the older store never appeared on the CDB after the branch");
        end
        check_eq(mem[st_addr[9:2]], st_data, "older store word");
        repeat (2) begin
            next_cycle();
            check_flag(cdb.valid, 1'b0, "CDB idle after the squash");
        end

        // not-taken BNE squashes nothing
        rob_head = 5'd10;
        a = $urandom;
        b = $urandom;
        issue[0] = make_issue(BNE, 5'd11, a, a, 32'h20, 32'h2000, 5'd0);
        issue[1] = make_issue(ADD, 5'd12, b, a, 32'h7, '0, 5'd6);
        next_cycle();
        issue = '0;
        check_flag(branch.valid, 1'b0, "branch valid for a not-taken BNE");
        check_eq(data_t'(cdb.rob_tag), 32'd11, "BNE tag on the CDB");
        next_cycle();
        check_eq(data_t'(cdb.rob_tag), 32'd12, "result after a not-taken BNE");
        check_eq(cdb.value, alu_model(ADD, b, a, 32'h7), "value after a not-taken BNE");
        check_flag(branch.valid, 1'b0, "branch valid for an ADD");
        next_cycle();

        total = value_errors + timeouts + DUT.u_props.fail_count;
        $display("errors: %0d value, %0d timeout, %0d assertion",
                 value_errors, timeouts, DUT.u_props.fail_count);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb/ex_properties.sv */
// timing rules of the execute stage; bound to ex_top, all but the reset check are off while rst_n is low
`timescale 1ns/1ps

module ex_properties
    import ex_types_pkg::*;
    import ex_packets_pkg::*;
(
    input logic                 clock,
    input logic                 rst_n,
    input fu_in_t  [NUM_FU-1:0] issue,
    input logic    [NUM_FU-1:0] fu_ready,
    input logic    [NUM_FU-1:0] ack,
    input fu_out_t [NUM_FU-1:0] fu_outs,
    input mem_req_t             mem_req,
    input cdb_t                 cdb,
    input branch_t              branch
);

    // number of failed checks so far
    int fail_count = 0;

    single_ack: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(ack))
    else begin
        fail_count++;
        $error("more than one unit was acked in one cycle");
    end

    branch_on_cdb: assert property (@(posedge clock) disable iff (!rst_n)
        branch.valid |-> cdb.valid)
    else begin
        fail_count++;
        $error("branch was valid without a CDB broadcast");
    end

    // no taken branch in this cycle, so the issue cannot be blocked
    alu0_latency: assert property (@(posedge clock) disable iff (!rst_n)
        issue[0].issue_valid && fu_ready[0] && !branch.valid |=> fu_outs[0].done)
    else begin
        fail_count++;
        $error("ALU 0 was not done one cycle after an accepted issue");
    end

    alu1_latency: assert property (@(posedge clock) disable iff (!rst_n)
        issue[1].issue_valid && fu_ready[1] && !branch.valid |=> fu_outs[1].done)
    else begin
        fail_count++;
        $error("ALU 1 was not done one cycle after an accepted issue");
    end

    quiet_after_reset: assert property (@(posedge clock)
        !rst_n |=> !cdb.valid && !branch.valid && !mem_req.valid && (&fu_ready))
    else begin
        fail_count++;
        $error("an output was active in the cycle after reset");
    end

endmodule

/* source/ex_top.sv */
// execute stage top; NUM_FU must stay 4 since the unit mix inside is fixed
`timescale 1ns/1ps

module ex_top
    import ex_types_pkg::*;
    import ex_packets_pkg::*;
#(
    parameter int NUM_FU = ex_types_pkg::NUM_FU
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  fu_in_t  [NUM_FU-1:0] issue,
    input  rob_tag_t             rob_head,
    input  data_t                mem_rdata,
    output logic    [NUM_FU-1:0] fu_ready,
    output mem_req_t             mem_req,
    output cdb_t                 cdb,
    output branch_t              branch
);

    fu_out_t [NUM_FU-1:0] fu_outs;
    logic    [NUM_FU-1:0] ack;

    ex_stage #(
        .NUM_FU (NUM_FU)
    ) u_ex_stage (
        .clock     (clock),
        .rst_n     (rst_n),
        .issue     (issue),
        .rob_head  (rob_head),
        .mem_rdata (mem_rdata),
        .ack       (ack),
        .fu_outs   (fu_outs),
        .fu_ready  (fu_ready),
        .mem_req   (mem_req),
        .branch    (branch)
    );

    cdb_arbiter #(
        .NUM_FU (NUM_FU)
    ) u_cdb_arbiter (
        .fu_outs (fu_outs),
        .ack     (ack),
        .cdb     (cdb)
    );

endmodule

/* source/ex_stage.sv */
// unit order is fixed: 0 and 1 ALU, 2 load, 3 store; a squashed store never gets the port
`timescale 1ns/1ps

module ex_stage
    import ex_types_pkg::*;
    import ex_packets_pkg::*;
#(
    parameter int NUM_FU = ex_types_pkg::NUM_FU
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  fu_in_t  [NUM_FU-1:0] issue,
    input  rob_tag_t             rob_head,
    input  data_t                mem_rdata,
    input  logic    [NUM_FU-1:0] ack,
    output fu_out_t [NUM_FU-1:0] fu_outs,
    output logic    [NUM_FU-1:0] fu_ready,
    output mem_req_t             mem_req,
    output branch_t              branch
);

    localparam int ALU0  = 0;
    localparam int ALU1  = 1;
    localparam int LOAD  = 2;
    localparam int STORE = 3;

    logic [NUM_FU-1:0] flush;
    logic [NUM_FU-1:0] block;
    mem_req_t          ld_req;
    mem_req_t          st_req;
    logic              ld_grant;
    logic              st_grant;

    // distance from the ROB head, modulo the tag range
    function automatic logic is_younger(rob_tag_t tag, rob_tag_t br_tag, rob_tag_t head);
        rob_tag_t dist_tag;
        rob_tag_t dist_br;
        dist_tag = tag - head;
        dist_br  = br_tag - head;
        return (tag != '0) && (dist_tag > dist_br);
    endfunction

    // only one ack per cycle, so at most one ALU can qualify
    always_comb begin
        branch = '0;
        if (ack[ALU0] && fu_outs[ALU0].take_branch) begin
            branch = '{valid: 1'b1, rob_tag: fu_outs[ALU0].rob_tag,
                       target: fu_outs[ALU0].branch_target};
        end else if (ack[ALU1] && fu_outs[ALU1].take_branch) begin
            branch = '{valid: 1'b1, rob_tag: fu_outs[ALU1].rob_tag,
                       target: fu_outs[ALU1].branch_target};
        end
    end

    // squash held work and offered issues that are younger than the branch
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            flush[i] = branch.valid && is_younger(fu_outs[i].rob_tag, branch.rob_tag, rob_head);
            block[i] = branch.valid && issue[i].issue_valid
                       && is_younger(issue[i].rob_tag, branch.rob_tag, rob_head);
        end
    end

    // loads always win the port
    assign ld_grant = ld_req.valid;
    assign st_grant = st_req.valid && !ld_req.valid && !flush[STORE];

    always_comb begin
        mem_req = '0;
        if (ld_grant) begin
            mem_req = ld_req;
        end else if (st_grant) begin
            mem_req = st_req;
        end
    end

    for (genvar i = ALU0; i <= ALU1; i++) begin : g_alu
        alu_fu u_alu (
            .clock  (clock),
            .rst_n  (rst_n),
            .flush  (flush[i]),
            .block  (block[i]),
            .ack    (ack[i]),
            .fu_in  (issue[i]),
            .fu_out (fu_outs[i]),
            .ready  (fu_ready[i])
        );
    end

    load_fu u_load (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (flush[LOAD]),
        .block     (block[LOAD]),
        .ack       (ack[LOAD]),
        .fu_in     (issue[LOAD]),
        .grant     (ld_grant),
        .mem_rdata (mem_rdata),
        .mem_req   (ld_req),
        .fu_out    (fu_outs[LOAD]),
        .ready     (fu_ready[LOAD])
    );

    store_fu u_store (
        .clock   (clock),
        .rst_n   (rst_n),
        .flush   (flush[STORE]),
        .block   (block[STORE]),
        .ack     (ack[STORE]),
        .fu_in   (issue[STORE]),
        .grant   (st_grant),
        .mem_req (st_req),
        .fu_out  (fu_outs[STORE]),
        .ready   (fu_ready[STORE])
    );

endmodule

/* source/cdb_arbiter.sv */
// fixed priority, lowest unit index wins; one broadcast and one ack per cycle
`timescale 1ns/1ps

module cdb_arbiter
    import ex_packets_pkg::*;
#(
    parameter int NUM_FU = ex_types_pkg::NUM_FU
) (
    input  fu_out_t [NUM_FU-1:0] fu_outs,
    output logic    [NUM_FU-1:0] ack,
    output cdb_t                 cdb
);

    always_comb begin
        logic found;
        found = 1'b0;
        ack   = '0;
        cdb   = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (fu_outs[i].done && !found) begin
                found        = 1'b1;
                ack[i]       = 1'b1;
                cdb.valid    = 1'b1;
                cdb.rob_tag  = fu_outs[i].rob_tag;
                cdb.dest_reg = fu_outs[i].dest_reg;
                cdb.value    = fu_outs[i].result;
            end
        end
    end

endmodule

/* source/store_fu.sv */
// full-word store written at execute; completion is reported with dest_reg 0
`timescale 1ns/1ps

module store_fu
    import ex_types_pkg::*;
    import ex_packets_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     block,
    input  logic     ack,
    input  fu_in_t   fu_in,
    input  logic     grant,
    output mem_req_t mem_req,
    output fu_out_t  fu_out,
    output logic     ready
);

    mem_fsm_t state_q;
    logic     take;
    rob_tag_t tag_q;
    addr_t    addr_q;
    data_t    wdata_q;

    assign ready = (state_q == IDLE) || (state_q == HOLD && ack);
    assign take  = fu_in.issue_valid && ready && !block;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else if (take) begin
            state_q <= WAIT_MEM;
        end else if (flush) begin
            state_q <= IDLE;
        end else if (state_q == WAIT_MEM && grant) begin
            // write happens in the grant cycle
            state_q <= HOLD;
        end else if (state_q == HOLD && ack) begin
            state_q <= IDLE;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            tag_q   <= fu_in.rob_tag;
            addr_q  <= fu_in.opa + fu_in.imm;
            wdata_q <= fu_in.opb;
        end
    end

    assign mem_req = '{valid: (state_q == WAIT_MEM), write: 1'b1, addr: addr_q, wdata: wdata_q};

    // nothing to write back, the ROB only needs the tag to retire
    assign fu_out = '{done:          (state_q == HOLD),
                      rob_tag:       tag_q,
                      dest_reg:      '0,
                      result:        '0,
                      take_branch:   1'b0,
                      branch_target: '0};

endmodule

/* source/load_fu.sv */
// full-word load; mem_rdata must be valid in the same cycle as the granted request
`timescale 1ns/1ps

module load_fu
    import ex_types_pkg::*;
    import ex_packets_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     block,
    input  logic     ack,
    input  fu_in_t   fu_in,
    input  logic     grant,
    input  data_t    mem_rdata,
    output mem_req_t mem_req,
    output fu_out_t  fu_out,
    output logic     ready
);

    mem_fsm_t state_q;
    logic     take;
    logic     capture;
    rob_tag_t tag_q;
    reg_idx_t dest_q;
    addr_t    addr_q;
    data_t    data_q;

    assign ready   = (state_q == IDLE) || (state_q == HOLD && ack);
    assign take    = fu_in.issue_valid && ready && !block;
    assign capture = (state_q == WAIT_MEM) && grant;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else if (take) begin
            state_q <= WAIT_MEM;
        end else if (flush) begin
            state_q <= IDLE;
        end else if (capture) begin
            state_q <= HOLD;
        end else if (state_q == HOLD && ack) begin
            state_q <= IDLE;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            tag_q  <= fu_in.rob_tag;
            dest_q <= fu_in.dest_reg;
            addr_q <= fu_in.opa + fu_in.imm;
        end
        if (capture) begin
            data_q <= mem_rdata;
        end
    end

    // request stays up until the port is ours
    assign mem_req = '{valid: (state_q == WAIT_MEM), write: 1'b0, addr: addr_q, wdata: '0};

    assign fu_out = '{done:          (state_q == HOLD),
                      rob_tag:       tag_q,
                      dest_reg:      dest_q,
                      result:        data_q,
                      take_branch:   1'b0,
                      branch_target: '0};

endmodule

/* source/alu_fu.sv */
// single-cycle ALU; result is held until acked, flush drops it, block ignores the issue slot
`timescale 1ns/1ps

module alu_fu
    import ex_types_pkg::*;
    import ex_packets_pkg::*;
(
    input  logic    clock,
    input  logic    rst_n,
    input  logic    flush,
    input  logic    block,
    input  logic    ack,
    input  fu_in_t  fu_in,
    output fu_out_t fu_out,
    output logic    ready
);

    data_t    src_b;
    data_t    alu_result;
    logic     alu_take;
    logic     take;
    logic     done_q;
    rob_tag_t tag_q;
    reg_idx_t dest_q;
    data_t    result_q;
    logic     take_q;
    addr_t    target_q;

    always_comb begin
        src_b = fu_in.imm;
        if (fu_in.alu_op inside {SUB, SLT, BEQ, BNE}) begin
            src_b = fu_in.opb;
        end
        alu_take   = 1'b0;
        alu_result = '0;
        case (fu_in.alu_op)
            ADD: alu_result = fu_in.opa + src_b;
            SUB: alu_result = fu_in.opa - src_b;
            AND: alu_result = fu_in.opa & src_b;
            OR:  alu_result = fu_in.opa | src_b;
            XOR: alu_result = fu_in.opa ^ src_b;
            SLT: alu_result = data_t'($signed(fu_in.opa) < $signed(src_b));
            BEQ: alu_take = (fu_in.opa == src_b);
            BNE: alu_take = (fu_in.opa != src_b);
            default: alu_result = '0;
        endcase
    end

    // free when empty or when the held result leaves this cycle
    assign ready = !done_q || ack;
    assign take  = fu_in.issue_valid && ready && !block;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (take) begin
            done_q <= 1'b1;
        end else if (flush || ack) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            tag_q    <= fu_in.rob_tag;
            dest_q   <= fu_in.dest_reg;
            result_q <= alu_result;
            take_q   <= alu_take;
            target_q <= fu_in.pc + fu_in.imm;
        end
    end

    assign fu_out = '{done:          done_q,
                      rob_tag:       tag_q,
                      dest_reg:      dest_q,
                      result:        result_q,
                      take_branch:   take_q,
                      branch_target: target_q};

endmodule

/* source/ex_packets_pkg.sv */
// bundles between units, arbiter and outside; every memory request moves one full word
package ex_packets_pkg;

    import ex_types_pkg::*;

    // one issue slot from a reservation station
    typedef struct packed {
        logic     issue_valid;
        rob_tag_t rob_tag;
        alu_op_t  alu_op;
        data_t    opa;
        data_t    opb;
        data_t    imm;
        addr_t    pc;
        reg_idx_t dest_reg;
    } fu_in_t;

    // result held by a unit until the CDB takes it
    typedef struct packed {
        logic     done;
        rob_tag_t rob_tag;
        reg_idx_t dest_reg;
        data_t    result;
        logic     take_branch;
        addr_t    branch_target;
    } fu_out_t;

    // single data memory port, full words only
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t rob_tag;
        reg_idx_t dest_reg;
        data_t    value;
    } cdb_t;

    // taken branch, valid only in the cycle its result is broadcast
    typedef struct packed {
        logic     valid;
        rob_tag_t rob_tag;
        addr_t    target;
    } branch_t;

endpackage

/* source/ex_types_pkg.sv */
// all words are 32 bits wide; rob tag 0 is reserved and means no instruction
package ex_types_pkg;

    localparam int XLEN   = 32;
    localparam int TAG_W  = 5;
    localparam int REG_W  = 5;
    // two ALUs, one load unit, one store unit
    localparam int NUM_FU = 4;

    typedef logic [XLEN-1:0]  data_t;
    typedef logic [XLEN-1:0]  addr_t;
    typedef logic [TAG_W-1:0] rob_tag_t;
    typedef logic [REG_W-1:0] reg_idx_t;

    // opb is the second operand only for SUB, SLT and branches, imm otherwise
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5,
        BEQ = 4'd6,
        BNE = 4'd7
    } alu_op_t;

    // memory unit FSM, shared by load and store
    typedef enum logic [1:0] {IDLE, WAIT_MEM, HOLD} mem_fsm_t;

endpackage
